// File: build.f
pipe_pkg.sv
stall_ctrl.sv
reg_file.sv
stage_buffer.sv
exec_unit.sv
decode_stage.sv
exec_pipeline.sv
tb_exec_pipeline.sv

// File: decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
    input  wire logic                 clock,
    input  wire logic                 rst_n,
    input  wire logic                 instr_valid,
    input  wire pipe_pkg::instr_t     instr,
    input  wire pipe_pkg::stall_t     stall,
    input  wire pipe_pkg::idex_t      ex_payload,
    input  wire pipe_pkg::exwb_t      wb_payload,
    input  wire pipe_pkg::exwb_t      ex_forward,
    output pipe_pkg::idex_t           id_payload,
    output logic                      id_stall_req
);

    logic                 if_valid;
    pipe_pkg::instr_t     if_instr;
    pipe_pkg::instr_t     cur;
    pipe_pkg::alu_op_t    alu_op;
    pipe_pkg::word_t      rs_data;
    pipe_pkg::word_t      rt_data;
    pipe_pkg::word_t      imm_value;
    logic                 is_itype;
    logic                 uses_rs;
    logic                 uses_rt;
    logic                 mul_dest;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            if_valid <= 1'b0;
        end else if (!stall[pipe_pkg::STALL_IFID]) begin
            if_valid <= instr_valid;                   // Idle fetch leaves an empty slot
        end
    end

    always_ff @(posedge clock) begin
        if (!stall[pipe_pkg::STALL_IFID]) begin
            if_instr <= instr;
        end
    end

    assign cur = if_valid ? if_instr : '0;            // Empty slot decodes as NOP

    reg_file u_reg_file (
        .clock   (clock),
        .rst_n   (rst_n),
        .rs_addr (cur.rs),
        .rt_addr (cur.low.r.rt),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .write   (wb_payload)
    );

    // Youngest producer first; a MUL in EX never matches since its enable is cleared
    function automatic pipe_pkg::word_t forward(input pipe_pkg::reg_addr_t addr,
                                                input pipe_pkg::word_t rf_value);
        if (addr == '0) begin
            return '0;
        end
        if (ex_forward.write_enable && ex_forward.write_addr == addr) begin
            return ex_forward.result;
        end
        if (wb_payload.write_enable && wb_payload.write_addr == addr) begin
            return wb_payload.result;
        end
        return rf_value;
    endfunction

    always_comb begin
        case (cur.opcode)
            pipe_pkg::OP_ADD:  alu_op = pipe_pkg::ALU_ADD;
            pipe_pkg::OP_SUB:  alu_op = pipe_pkg::ALU_SUB;
            pipe_pkg::OP_AND:  alu_op = pipe_pkg::ALU_AND;
            pipe_pkg::OP_OR:   alu_op = pipe_pkg::ALU_OR;
            pipe_pkg::OP_XOR:  alu_op = pipe_pkg::ALU_XOR;
            pipe_pkg::OP_SLT:  alu_op = pipe_pkg::ALU_SLT;
            pipe_pkg::OP_ADDI: alu_op = pipe_pkg::ALU_ADD;
            pipe_pkg::OP_LUI:  alu_op = pipe_pkg::ALU_LUI;
            pipe_pkg::OP_MUL:  alu_op = pipe_pkg::ALU_MUL;
            default:           alu_op = pipe_pkg::ALU_NOP;   // Unknown opcodes fall through here
        endcase
    end

    assign is_itype  = cur.opcode == pipe_pkg::OP_ADDI || cur.opcode == pipe_pkg::OP_LUI;
    assign uses_rs   = alu_op != pipe_pkg::ALU_NOP && alu_op != pipe_pkg::ALU_LUI;
    assign uses_rt   = alu_op != pipe_pkg::ALU_NOP && !is_itype;
    assign imm_value = (cur.opcode == pipe_pkg::OP_LUI) ? {cur.low.imm, 16'h0000}
                                                        : {{16{cur.low.imm[15]}}, cur.low.imm};

    always_comb begin
        id_payload.alu_op       = alu_op;
        case (alu_op)
            pipe_pkg::ALU_ADD, pipe_pkg::ALU_SUB, pipe_pkg::ALU_SLT:
                id_payload.category = pipe_pkg::CAT_ARITH;
            pipe_pkg::ALU_MUL: id_payload.category = pipe_pkg::CAT_MUL;
            pipe_pkg::ALU_NOP: id_payload.category = pipe_pkg::CAT_NONE;
            default:           id_payload.category = pipe_pkg::CAT_LOGIC;
        endcase
        id_payload.operand1     = forward(cur.rs, rs_data);
        id_payload.operand2     = is_itype ? imm_value : forward(cur.low.r.rt, rt_data);
        id_payload.write_addr   = cur.rd;
        id_payload.write_enable = alu_op != pipe_pkg::ALU_NOP;
        id_payload.instruction  = cur;
    end

    // Product is not ready until it lands in EX/WB
    assign mul_dest     = ex_payload.category == pipe_pkg::CAT_MUL && ex_payload.write_enable
                          && ex_payload.write_addr != '0;
    assign id_stall_req = mul_dest && ((uses_rs && cur.rs == ex_payload.write_addr)
                          || (uses_rt && cur.low.r.rt == ex_payload.write_addr));

    assert property (@(posedge clock) disable iff (!rst_n) $rose(id_stall_req) |-> if_valid)
        else $error("decode_stage: hazard raised on an empty IF/ID slot");

    // Once EX is free the bubble clears the hazard in one cycle
    assert property (@(posedge clock) disable iff (!rst_n)
        id_stall_req && !stall[pipe_pkg::STALL_EX] |=> !id_stall_req)
        else $error("decode_stage: MUL hazard held longer than one cycle");

endmodule

`default_nettype wire

// File: exec_pipeline.sv
`timescale 1ns/10ps
`default_nettype none

module exec_pipeline #(
    parameter int MUL_BITS_PER_CYCLE = 4
) (
    input  wire logic                 clock,
    input  wire logic                 rst_n,
    input  wire logic                 instr_valid,
    input  wire pipe_pkg::instr_t     instr,
    output logic                      instr_ready,
    output pipe_pkg::wb_t             wb
);

    pipe_pkg::stall_t     stall;
    pipe_pkg::buf_ctl_t   idex_ctl;
    pipe_pkg::buf_ctl_t   exwb_ctl;
    logic                 id_stall_req;
    logic                 ex_stall_req;
    pipe_pkg::idex_t      id_payload;
    pipe_pkg::idex_t      ex_payload;
    pipe_pkg::exwb_t      ex_result;
    pipe_pkg::exwb_t      ex_forward;
    pipe_pkg::exwb_t      wb_payload;

    stall_ctrl u_stall_ctrl (
        .id_stall_req (id_stall_req),
        .ex_stall_req (ex_stall_req),
        .stall        (stall),
        .idex_ctl     (idex_ctl),
        .exwb_ctl     (exwb_ctl)
    );

    decode_stage u_decode_stage (
        .clock        (clock),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .stall        (stall),
        .ex_payload   (ex_payload),
        .wb_payload   (wb_payload),
        .ex_forward   (ex_forward),
        .id_payload   (id_payload),
        .id_stall_req (id_stall_req)
    );

    stage_buffer #(.payload_t(pipe_pkg::idex_t)) idex_buffer (
        .clock (clock),
        .rst_n (rst_n),
        .ctl   (idex_ctl),
        .d     (id_payload),
        .q     (ex_payload)
    );

    exec_unit #(.MUL_BITS_PER_CYCLE(MUL_BITS_PER_CYCLE)) u_exec_unit (
        .clock        (clock),
        .rst_n        (rst_n),
        .ex_payload   (ex_payload),
        .ex_result    (ex_result),
        .ex_forward   (ex_forward),
        .ex_stall_req (ex_stall_req)
    );

    stage_buffer #(.payload_t(pipe_pkg::exwb_t)) exwb_buffer (
        .clock (clock),
        .rst_n (rst_n),
        .ctl   (exwb_ctl),
        .d     (ex_result),
        .q     (wb_payload)
    );

    assign instr_ready = !stall[pipe_pkg::STALL_FETCH];

    // Writes to r0 are architecturally invisible
    assign wb.valid = wb_payload.write_enable && wb_payload.write_addr != '0;
    assign wb.addr  = wb_payload.write_addr;
    assign wb.data  = wb_payload.result;

endmodule

`default_nettype wire

// File: exec_unit.sv
`timescale 1ns/10ps
`default_nettype none

module exec_unit #(
    parameter int MUL_BITS_PER_CYCLE = 4
) (
    input  wire logic                 clock,
    input  wire logic                 rst_n,
    input  wire pipe_pkg::idex_t      ex_payload,
    output pipe_pkg::exwb_t           ex_result,
    output pipe_pkg::exwb_t           ex_forward,
    output logic                      ex_stall_req
);

    localparam int STEPS = pipe_pkg::WORD_W / MUL_BITS_PER_CYCLE;
    localparam int CNT_W = $clog2(STEPS);

    logic              busy;
    logic [CNT_W-1:0]  count;
    logic [CNT_W-1:0]  cur_count;
    logic              is_mul;
    logic              mul_start;
    logic              mul_last;
    pipe_pkg::word_t   acc;
    pipe_pkg::word_t   mcand;
    pipe_pkg::word_t   mplier;
    pipe_pkg::word_t   cur_acc;
    pipe_pkg::word_t   cur_mcand;
    pipe_pkg::word_t   cur_mplier;
    pipe_pkg::word_t   partial;
    pipe_pkg::word_t   next_acc;
    pipe_pkg::word_t   alu_result;

    assign is_mul    = ex_payload.category == pipe_pkg::CAT_MUL;
    assign mul_start = is_mul && !busy;

    // First step works straight off the operands, later steps off the saved state
    assign cur_acc    = busy ? acc : '0;
    assign cur_mcand  = busy ? mcand : ex_payload.operand1;
    assign cur_mplier = busy ? mplier : ex_payload.operand2;
    assign cur_count  = busy ? count : '0;
    assign mul_last   = cur_count == CNT_W'(STEPS - 1);

    assign ex_stall_req = is_mul && !mul_last;

    always_comb begin
        partial = '0;
        for (int i = 0; i < MUL_BITS_PER_CYCLE; i++) begin
            if (cur_mplier[i]) begin
                partial = partial + (cur_mcand << i);
            end
        end
    end

    assign next_acc = cur_acc + partial;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            count <= '0;
        end else begin
            busy  <= ex_stall_req;
            count <= ex_stall_req ? cur_count + CNT_W'(1) : '0;
        end
    end

    always_ff @(posedge clock) begin
        if (ex_stall_req) begin
            acc    <= next_acc;
            mcand  <= cur_mcand << MUL_BITS_PER_CYCLE;
            mplier <= cur_mplier >> MUL_BITS_PER_CYCLE;
        end
    end

    always_comb begin
        case (ex_payload.alu_op)
            pipe_pkg::ALU_ADD: alu_result = ex_payload.operand1 + ex_payload.operand2;
            pipe_pkg::ALU_SUB: alu_result = ex_payload.operand1 - ex_payload.operand2;
            pipe_pkg::ALU_AND: alu_result = ex_payload.operand1 & ex_payload.operand2;
            pipe_pkg::ALU_OR:  alu_result = ex_payload.operand1 | ex_payload.operand2;
            pipe_pkg::ALU_XOR: alu_result = ex_payload.operand1 ^ ex_payload.operand2;
            pipe_pkg::ALU_SLT: alu_result = pipe_pkg::word_t'(
                $signed(ex_payload.operand1) < $signed(ex_payload.operand2));
            pipe_pkg::ALU_LUI: alu_result = ex_payload.operand2;   // Shifted in decode
            pipe_pkg::ALU_MUL: alu_result = next_acc;              // Only sampled on the last step
            default:           alu_result = '0;
        endcase
    end

    always_comb begin
        ex_result.write_addr   = ex_payload.write_addr;
        ex_result.write_enable = ex_payload.write_enable;
        ex_result.result       = alu_result;
        ex_forward             = ex_result;
        if (is_mul) begin
            ex_forward.write_enable = 1'b0;                        // Product only forwarded from EX/WB
        end
    end

    // A started multiply runs its full step count without being restarted
    assert property (@(posedge clock) disable iff (!rst_n)
        mul_start |=> (busy && !mul_start) [*(STEPS - 1)] ##1 !busy)
        else $error("exec_unit: multiplier restarted or ended early");

endmodule

`default_nettype wire

// File: pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    localparam int WORD_W    = 32;
    localparam int REG_COUNT = 32;

    // Bit positions inside the stall vector
    localparam int STALL_FETCH = 0;
    localparam int STALL_IFID  = 1;
    localparam int STALL_IDEX  = 2;
    localparam int STALL_EX    = 3;

    typedef logic [WORD_W-1:0]            word_t;
    typedef logic [$clog2(REG_COUNT)-1:0] reg_addr_t;
    typedef logic [3:0]                   stall_t;

    typedef enum logic [5:0] {
        OP_NOP  = 6'd0,
        OP_ADD  = 6'd1,
        OP_SUB  = 6'd2,
        OP_AND  = 6'd3,
        OP_OR   = 6'd4,
        OP_XOR  = 6'd5,
        OP_SLT  = 6'd6,
        OP_ADDI = 6'd7,
        OP_LUI  = 6'd8,
        OP_MUL  = 6'd9
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_LUI, ALU_MUL
    } alu_op_t;

    typedef enum logic [1:0] {
        CAT_NONE, CAT_ARITH, CAT_LOGIC, CAT_MUL
    } category_t;

    typedef enum logic [1:0] {
        BUF_ADVANCE, BUF_HOLD, BUF_BUBBLE
    } buf_ctl_t;

    typedef struct packed {
        reg_addr_t   rt;
        logic [10:0] spare;
    } rtype_low_t;

    // R-type reads rt from the top of the low half, I-type reads all 16 bits as imm
    typedef union packed {
        rtype_low_t  r;
        logic [15:0] imm;
    } instr_low_t;

    typedef struct packed {
        logic [5:0] opcode;                // Kept raw so unknown codes survive to decode
        reg_addr_t  rd;
        reg_addr_t  rs;
        instr_low_t low;
    } instr_t;

    typedef struct packed {
        alu_op_t   alu_op;
        category_t category;
        word_t     operand1;
        word_t     operand2;
        reg_addr_t write_addr;
        logic      write_enable;
        instr_t    instruction;
    } idex_t;

    typedef struct packed {
        reg_addr_t write_addr;
        logic      write_enable;
        word_t     result;
    } exwb_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t addr;
        word_t     data;
    } wb_t;

endpackage

`default_nettype wire

// File: reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  wire logic                 clock,
    input  wire logic                 rst_n,
    input  wire pipe_pkg::reg_addr_t  rs_addr,
    input  wire pipe_pkg::reg_addr_t  rt_addr,
    output pipe_pkg::word_t           rs_data,
    output pipe_pkg::word_t           rt_data,
    input  wire pipe_pkg::exwb_t      write
);

    pipe_pkg::word_t regs [pipe_pkg::REG_COUNT];

    // Same-cycle write is visible on the read port
    function automatic pipe_pkg::word_t read_port(input pipe_pkg::reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (write.write_enable && write.write_addr == addr) begin
            return write.result;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < pipe_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write.write_enable && write.write_addr != '0) begin
            regs[write.write_addr] <= write.result;     // r0 stays hard-wired to zero
        end
    end

    always_comb begin
        rs_data = read_port(rs_addr);
        rt_data = read_port(rt_addr);
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Compile and run the execution pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_exec_pipeline -Mdir obj_dir -f build.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/Vtb_exec_pipeline > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "TESTBENCH FAILED" "$LOG"; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
exit 0

// File: stage_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module stage_buffer #(
    parameter type payload_t = logic
) (
    input  wire logic                 clock,
    input  wire logic                 rst_n,
    input  wire pipe_pkg::buf_ctl_t   ctl,
    input  wire payload_t             d,
    output payload_t                  q
);

    // An all-zero payload decodes as a NOP that writes nothing
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else begin
            case (ctl)
                pipe_pkg::BUF_ADVANCE: begin
                    q <= d;
                end
                pipe_pkg::BUF_BUBBLE: begin
                    q <= '0;                           // Upstream stalled, downstream runs
                end
                default: begin
                    q <= q;                            // Hold while the next stage is busy
                end
            endcase
        end
    end

    // An unknown command would silently corrupt the pipeline contents
    assert property (@(posedge clock) disable iff (!rst_n) !$isunknown(ctl))
        else $error("stage_buffer: control is unknown");

endmodule

`default_nettype wire

// File: stall_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module stall_ctrl (
    input  wire logic                 id_stall_req,
    input  wire logic                 ex_stall_req,
    output pipe_pkg::stall_t          stall,
    output pipe_pkg::buf_ctl_t        idex_ctl,
    output pipe_pkg::buf_ctl_t        exwb_ctl
);

    // A stalled stage whose successor still runs must hand a bubble downstream
    function automatic pipe_pkg::buf_ctl_t buf_cmd(input logic stalled, input logic next_stalled);
        if (!stalled) begin
            return pipe_pkg::BUF_ADVANCE;
        end
        return next_stalled ? pipe_pkg::BUF_HOLD : pipe_pkg::BUF_BUBBLE;
    endfunction

    always_comb begin
        stall = '0;
        if (ex_stall_req) begin
            stall = '1;                                    // Multiplier busy, freeze all stages
        end else if (id_stall_req) begin
            stall[pipe_pkg::STALL_FETCH] = 1'b1;
            stall[pipe_pkg::STALL_IFID]  = 1'b1;
            stall[pipe_pkg::STALL_IDEX]  = 1'b1;          // EX keeps running to drain the MUL
        end
    end

    always_comb begin
        idex_ctl = buf_cmd(stall[pipe_pkg::STALL_IDEX], stall[pipe_pkg::STALL_EX]);
        exwb_ctl = buf_cmd(stall[pipe_pkg::STALL_EX], 1'b0);  // Writeback never stalls
    end

    // Execute stall must win over a decode hazard in both buffer commands
    always_comb begin
        if (ex_stall_req) begin
            assert (idex_ctl == pipe_pkg::BUF_HOLD && exwb_ctl == pipe_pkg::BUF_BUBBLE)
                else $error("stall_ctrl: execute stall not translated to hold and bubble");
        end
    end

endmodule

`default_nettype wire

// File: tb_exec_pipeline.sv
`timescale 1ns/10ps
`default_nettype none

module tb_exec_pipeline;

    localparam int NUM_INSTR      = 400;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int QUIET_CYCLES   = 8;

    typedef struct packed {
        logic [4:0]  addr;
        logic [31:0] data;
    } expect_t;

    logic              clock;
    logic              rst_n;
    logic              instr_valid;
    pipe_pkg::instr_t  instr;
    logic              instr_ready;
    pipe_pkg::wb_t     wb;

    integer            seed;
    logic [31:0]       arch_regs [32];
    expect_t           expected_q [$];
    logic [31:0]       cur_word;
    int                accepted_count;
    int                mul_count;
    int                ready_low_cycles;

    exec_pipeline #(.MUL_BITS_PER_CYCLE(4)) UUT (
        .clock       (clock),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .wb          (wb)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping after a failed check");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            report_failure($sformatf("error: %s got 0x%08h expected 0x%08h", name, got, expected));
        end
    endtask

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Mostly r0 to r4 so that back-to-back instructions depend on each other
    function automatic logic [4:0] pick_reg();
        if (rand_below(8) < 7) begin
            return 5'(rand_below(5));
        end
        return 5'(rand_below(32));
    endfunction

    function automatic logic [31:0] random_instr();
        int unsigned pick;
        logic [5:0]  opcode;
        logic [15:0] low;
        pick = rand_below(12);
        if (pick < 10) begin
            opcode = 6'(pick);                                 // One of the ten defined operations
        end else begin
            opcode = 6'(10 + rand_below(54));                  // Undefined code that decodes as NOP
        end
        if (opcode == pipe_pkg::OP_ADDI || opcode == pipe_pkg::OP_LUI) begin
            low = 16'($random(seed));
        end else begin
            low = {pick_reg(), 11'(rand_below(2048))};
        end
        return {opcode, pick_reg(), pick_reg(), low};
    endfunction

    // Sequential reference execution of one accepted instruction
    task automatic execute_model(input logic [31:0] word);
        logic [5:0]  opcode;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_sext;
        logic [31:0] result;
        logic        writes;
        expect_t     entry;
        opcode   = word[31:26];
        rd       = word[25:21];
        a        = arch_regs[word[20:16]];
        b        = arch_regs[word[15:11]];
        imm_sext = {{16{word[15]}}, word[15:0]};
        writes   = 1'b1;
        result   = '0;
        case (opcode)
            pipe_pkg::OP_ADD:  result = a + b;
            pipe_pkg::OP_SUB:  result = a - b;
            pipe_pkg::OP_AND:  result = a & b;
            pipe_pkg::OP_OR:   result = a | b;
            pipe_pkg::OP_XOR:  result = a ^ b;
            pipe_pkg::OP_SLT:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            pipe_pkg::OP_ADDI: result = a + imm_sext;
            pipe_pkg::OP_LUI:  result = {word[15:0], 16'h0000};
            pipe_pkg::OP_MUL:  result = a * b;                  // Keeps the low 32 bits
            default:           writes = 1'b0;
        endcase
        if (opcode == pipe_pkg::OP_MUL) begin
            mul_count++;
        end
        if (writes && rd != 5'd0) begin
            arch_regs[rd] = result;
            entry.addr    = rd;
            entry.data    = result;
            expected_q.push_back(entry);
        end
    endtask

    task automatic check_writeback();
        expect_t entry;
        if (wb.valid === 1'b1) begin
            if (expected_q.size() == 0) begin
                report_failure("writeback report arrived with no write pending in the model");
            end else begin
                entry = expected_q.pop_front();
                check_value("wb.addr", 32'(wb.addr), 32'(entry.addr));
                check_value("wb.data", wb.data, entry.data);
            end
        end else begin
            check_value("wb.valid", 32'(wb.valid), 32'd0);
        end
    endtask

    initial begin
        int   issued;
        int   waited;
        logic pending;
        seed             = 32'h32ba_65da;
        rst_n            = 1'b0;
        instr_valid      = 1'b0;
        instr            = '0;
        cur_word         = '0;
        accepted_count   = 0;
        mul_count        = 0;
        ready_low_cycles = 0;
        for (int i = 0; i < 32; i++) begin
            arch_regs[i] = '0;
        end
        repeat (3) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;

        issued  = 0;
        waited  = 0;
        pending = 1'b0;
        while (issued < NUM_INSTR) begin
            @(negedge clock);
            if (accepted_count == 0) begin
                check_value("wb.valid", 32'(wb.valid), 32'd0);     // Idle pipeline after reset
                check_value("instr_ready", 32'(instr_ready), 32'd1);
            end
            check_writeback();
            if (!instr_ready) begin
                ready_low_cycles++;
            end
            if (!pending) begin
                if (rand_below(4) == 0) begin
                    instr_valid = 1'b0;                        // Random fetch gap
                end else begin
                    cur_word    = random_instr();
                    instr       = cur_word;
                    instr_valid = 1'b1;
                end
            end
            // Ready depends only on pipeline state, so it already holds for the next edge
            if (instr_valid && instr_ready) begin
                execute_model(cur_word);
                accepted_count++;
                issued++;
                pending = 1'b0;
                waited  = 0;
            end else if (instr_valid) begin
                pending = 1'b1;
                waited++;
                if (waited > TIMEOUT_CYCLES) begin
                    report_failure("timed out waiting for instr_ready");
                end
            end
        end

        waited = 0;
        while (expected_q.size() != 0) begin
            @(negedge clock);
            instr_valid = 1'b0;
            check_writeback();
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                report_failure("timed out draining the pipeline with writes still outstanding");
            end
        end
        for (int i = 0; i < QUIET_CYCLES; i++) begin
            @(negedge clock);
            instr_valid = 1'b0;
            check_writeback();                                 // Any late report is spurious
        end

        if (mul_count == 0) begin
            report_failure("no multiply instruction was accepted");
        end else if (ready_low_cycles == 0) begin
            report_failure("instr_ready never dropped during a multiply");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire
